/* logic/nn_isa_pkg.sv */
// Instruction word layout, opcodes and opcode classes, imported wherever instructions are decoded
`default_nettype none

package nn_isa_pkg;

	typedef logic [16:0] maddr_t; // Memory address field
	typedef logic [8:0] caddr_t;  // Coefficient address that doubles as store shift

	typedef enum logic [5:0] {
		OP_LOAD_COEFF0 = 6'd5,
		OP_LOAD_COEFF1 = 6'd6,
		OP_SET_VBP     = 6'd8,
		OP_ADD_VBP     = 6'd9,
		OP_SET_SBP     = 6'd12,
		OP_ADD_SBP     = 6'd13,
		OP_STORE       = 6'd16,
		OP_STORE0      = 6'd17,
		OP_STORE1      = 6'd18,
		OP_RELU        = 6'd20,
		OP_RELU0       = 6'd21,
		OP_RELU1       = 6'd22,
		OP_SAVE        = 6'd24,
		OP_SAVE0       = 6'd25,
		OP_SAVE1       = 6'd26,
		OP_MACC        = 6'd40,
		OP_MACCZ       = 6'd42
	} opcode_t;

	// Bits 31..15, 14..6, 5..0
	typedef struct packed {
		maddr_t  maddr;
		caddr_t  caddr;
		opcode_t op;
	} insn_t;

	function automatic logic is_mem_read(opcode_t op);
		return op inside {OP_LOAD_COEFF0, OP_LOAD_COEFF1, OP_MACC, OP_MACCZ};
	endfunction

	function automatic logic is_mem_write(opcode_t op);
		return op inside {OP_STORE, OP_STORE0, OP_STORE1, OP_RELU, OP_RELU0, OP_RELU1,
			OP_SAVE, OP_SAVE0, OP_SAVE1};
	endfunction

	function automatic logic is_coeff_load(opcode_t op);
		return op inside {OP_LOAD_COEFF0, OP_LOAD_COEFF1};
	endfunction

endpackage

`default_nettype wire

/* logic/nn_arch_pkg.sv */
// Datapath widths and pipeline depths of the compute unit, imported by every pipeline block
`default_nettype none

package nn_arch_pkg;

	localparam int NUM_LANES = 2; // Store format has one byte per lane

	typedef logic [63:0] mem_word_t;
	typedef logic [15:0] mem_addr_t;  // Word address
	typedef logic [7:0] mem_wen_t;    // One enable per byte
	typedef logic signed [31:0] acc_t;
	typedef logic signed [19:0] sum_t; // Holds eight byte products without overflow

	// Read data arrives after the third edge following the request
	localparam int MEM_READ_LATENCY = 3;
	localparam int FETCH_STAGES = 4;  // Acceptance to read capture minus one
	localparam int LANE_LATENCY = 4;  // Products, sum, accumulator, saturation
	localparam int PIPE_DEPTH = 10;   // Acceptance to the write registers

endpackage

`default_nettype wire

/* logic/nn_feed_if.sv */
// Operand bundle handed from operand fetch to the MAC lanes and the write-back stage
`timescale 1ns/1ps
`default_nettype none

interface nn_feed_if;
	import nn_isa_pkg::*;
	import nn_arch_pkg::*;

	logic      valid;
	opcode_t   op;
	maddr_t    maddr;
	caddr_t    shift;            // Store shift amount
	mem_word_t data;             // Eight signed data bytes
	mem_word_t coeff [NUM_LANES]; // Coefficient word per lane

	modport source (output valid, op, maddr, shift, data, coeff);
	modport lane (input valid, op, shift, data, coeff);
	modport sink (input valid, op, maddr);

endinterface

`default_nettype wire

/* logic/nn_issue.sv */
// Instruction intake with the memory and coefficient interlocks, VBP and the read request
`timescale 1ns/1ps
`default_nettype none

module nn_issue (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   cmd_valid,
	output logic                   cmd_ready,
	input  nn_isa_pkg::insn_t      cmd_insn,
	output logic                   busy,
	output logic                   issue_valid,
	output nn_isa_pkg::insn_t      issue_insn,
	output logic                   rd_en,
	output nn_arch_pkg::mem_addr_t rd_addr
);
	import nn_isa_pkg::*;
	import nn_arch_pkg::*;

	logic hold_valid;
	insn_t hold_insn;
	logic stall;
	logic leave;
	maddr_t vbp;
	maddr_t rd_maddr;
	logic [PIPE_DEPTH-1:0] wr_flags;   // Writes past E1 up to E10
	logic [FETCH_STAGES:0] cl_flags;   // Coefficient loads past E1 up to E5
	logic [PIPE_DEPTH-1:0] any_flags;  // Every item in flight

	always_comb begin
		stall = 1'b0;
		// Reads wait until pending stores have reached memory
		if (hold_valid && is_mem_read(hold_insn.op) && (|wr_flags))
			stall = 1'b1;
		if (hold_valid && hold_insn.op inside {OP_MACC, OP_MACCZ} && (|cl_flags))
			stall = 1'b1; // Coefficients not written yet
	end

	assign leave = hold_valid && !stall;
	assign cmd_ready = !stall;
	assign busy = hold_valid || (|any_flags);

	assign rd_maddr = is_coeff_load(hold_insn.op) ? hold_insn.maddr : hold_insn.maddr + vbp;

	always_ff @(posedge clock) begin
		if (reset) begin
			hold_valid <= 1'b0;
			issue_valid <= 1'b0;
			rd_en <= 1'b0;
			wr_flags <= '0;
			cl_flags <= '0;
			any_flags <= '0;
		end else begin
			if (!stall)
				hold_valid <= cmd_valid;
			issue_valid <= leave;
			rd_en <= leave && is_mem_read(hold_insn.op);
			wr_flags <= {wr_flags[PIPE_DEPTH-2:0], leave && is_mem_write(hold_insn.op)};
			cl_flags <= {cl_flags[FETCH_STAGES-1:0], leave && is_coeff_load(hold_insn.op)};
			any_flags <= {any_flags[PIPE_DEPTH-2:0], leave};
		end
	end

	always_ff @(posedge clock) begin
		if (!stall)
			hold_insn <= cmd_insn;
		issue_insn <= hold_insn;
		rd_addr <= rd_maddr[16:1]; // Byte pair address to word address
		// VBP changes at E1 so the next read already sees it
		if (leave && hold_insn.op inside {OP_SET_VBP, OP_ADD_VBP})
			vbp <= hold_insn.maddr + (hold_insn.op == OP_ADD_VBP ? vbp : '0);
	end

	// No store is left in flight once a read has gone out
	assert property (@(posedge clock) disable iff (reset)
		rd_en |-> wr_flags == '0);

endmodule

`default_nettype wire

/* logic/nn_operand_fetch.sv */
// Delays issued items to the read data, reads and loads coefficients, and drives the feed
`timescale 1ns/1ps
`default_nettype none

module nn_operand_fetch #(
	parameter int COEFF_DEPTH = 512
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   issue_valid,
	input  nn_isa_pkg::insn_t      issue_insn,
	input  nn_arch_pkg::mem_word_t mem_rdata,
	nn_feed_if.source              feed
);
	import nn_isa_pkg::*;
	import nn_arch_pkg::*;

	localparam int DELAY = MEM_READ_LATENCY; // Items travel alongside their memory read
	localparam int CA_W = $clog2(COEFF_DEPTH);

	logic [DELAY-1:0] pipe_valid;
	insn_t pipe_insn [DELAY];
	insn_t cap_insn;
	mem_word_t coeff_mem [COEFF_DEPTH][NUM_LANES];
	mem_word_t coeff_q [NUM_LANES];
	logic [CA_W-1:0] rd_index;
	logic [CA_W-1:0] wr_index;

	assign cap_insn = pipe_insn[DELAY-1];
	assign rd_index = pipe_insn[DELAY-2].caddr[CA_W-1:0];
	assign wr_index = cap_insn.caddr[CA_W-1:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			pipe_valid <= '0;
			feed.valid <= 1'b0;
		end else begin
			pipe_valid <= {pipe_valid[DELAY-2:0], issue_valid};
			feed.valid <= pipe_valid[DELAY-1];
		end
	end

	always_ff @(posedge clock) begin
		pipe_insn[0] <= issue_insn;
		for (int i = 1; i < DELAY; i++)
			pipe_insn[i] <= pipe_insn[i-1];
		coeff_q <= coeff_mem[rd_index]; // Read at E4
		feed.op <= cap_insn.op;
		feed.maddr <= cap_insn.maddr;
		feed.shift <= cap_insn.caddr;
		feed.data <= mem_rdata;         // Capture at E5
		feed.coeff <= coeff_q;
	end

	// Loaded words land in one lane half of the addressed row
	always_ff @(posedge clock) begin
		if (pipe_valid[DELAY-1] && cap_insn.op == OP_LOAD_COEFF0)
			coeff_mem[wr_index][0] <= mem_rdata;
		if (pipe_valid[DELAY-1] && cap_insn.op == OP_LOAD_COEFF1)
			coeff_mem[wr_index][1] <= mem_rdata;
	end

	// Issue interlock keeps a coefficient read away from a pending load
	assert property (@(posedge clock) disable iff (reset)
		pipe_valid[DELAY-2] && pipe_insn[DELAY-2].op inside {OP_MACC, OP_MACCZ}
		|-> !(pipe_valid[DELAY-1] && is_coeff_load(cap_insn.op)));

endmodule

`default_nettype wire

/* logic/nn_mac_lane.sv */
// One multiply-accumulate lane; instantiated once per lane with its index as LANE
`timescale 1ns/1ps
`default_nettype none

module nn_mac_lane #(
	parameter int LANE = 0
) (
	input  logic              clock,
	input  logic              reset,
	nn_feed_if.lane           feed,
	output nn_arch_pkg::acc_t acc,
	output logic [7:0]        sat
);
	import nn_isa_pkg::*;
	import nn_arch_pkg::*;

	localparam int STAGES = LANE_LATENCY - 1;

	logic [STAGES-1:0] st_valid;
	opcode_t st_op [STAGES];
	caddr_t st_shift [STAGES];
	logic signed [15:0] prod [8];
	sum_t sum;
	acc_t acc_q;
	acc_t shifted;
	logic [7:0] sat_next;

	// Arithmetic shift then clamp to a signed byte
	always_comb begin
		shifted = acc_q >>> st_shift[STAGES-1];
		if (shifted > 127)
			sat_next = 8'h7f;
		else if (shifted < -128)
			sat_next = 8'h80;
		else
			sat_next = shifted[7:0];
	end

	always_ff @(posedge clock) begin
		if (reset)
			st_valid <= '0;
		else
			st_valid <= {st_valid[STAGES-2:0], feed.valid};
	end

	always_ff @(posedge clock) begin
		st_op[0] <= feed.op;
		st_shift[0] <= feed.shift;
		for (int i = 1; i < STAGES; i++) begin
			st_op[i] <= st_op[i-1];
			st_shift[i] <= st_shift[i-1];
		end
		for (int b = 0; b < 8; b++)
			prod[b] <= $signed(feed.data[8*b +: 8]) * $signed(feed.coeff[LANE][8*b +: 8]);
		sum <= prod[0] + prod[1] + prod[2] + prod[3] +
			prod[4] + prod[5] + prod[6] + prod[7];
		if (st_valid[STAGES-2] && st_op[STAGES-2] == OP_MACC)
			acc_q <= acc_q + sum;
		if (st_valid[STAGES-2] && st_op[STAGES-2] == OP_MACCZ)
			acc_q <= sum; // Start a new dot product
		if (st_valid[STAGES-1] && is_mem_write(st_op[STAGES-1])) begin
			acc <= acc_q; // Snapshot so later MACCs may follow right away
			sat <= sat_next;
		end
	end

endmodule

`default_nettype wire

/* logic/nn_writeback.sv */
// Store base pointer, write word formation and the shared memory port of the compute unit
`timescale 1ns/1ps
`default_nettype none

module nn_writeback (
	input  logic                   clock,
	input  logic                   reset,
	nn_feed_if.sink                feed,
	input  nn_arch_pkg::acc_t      acc [nn_arch_pkg::NUM_LANES],
	input  logic [7:0]             sat [nn_arch_pkg::NUM_LANES],
	input  logic                   rd_en,
	input  nn_arch_pkg::mem_addr_t rd_addr,
	output logic                   mem_ren,
	output nn_arch_pkg::mem_wen_t  mem_wen,
	output nn_arch_pkg::mem_addr_t mem_addr,
	output nn_arch_pkg::mem_word_t mem_wdata
);
	import nn_isa_pkg::*;
	import nn_arch_pkg::*;

	logic [LANE_LATENCY-1:0] dly_valid;
	opcode_t dly_op [LANE_LATENCY];
	maddr_t dly_maddr [LANE_LATENCY];
	logic wb_valid;
	opcode_t wb_op;
	maddr_t sbp;
	logic [7:0] byte0;
	logic [7:0] byte1;
	mem_wen_t wen_next;
	mem_word_t wdata_next;
	mem_wen_t wr_en;
	maddr_t wr_addr;
	mem_word_t wr_data;

	assign wb_valid = dly_valid[LANE_LATENCY-1];
	assign wb_op = dly_op[LANE_LATENCY-1];

	always_comb begin
		byte0 = sat[0];
		byte1 = sat[1];
		if (wb_op inside {OP_RELU, OP_RELU0, OP_RELU1}) begin
			if (byte0[7])
				byte0 = '0;
			if (byte1[7])
				byte1 = '0;
		end
		wdata_next = {48'd0, byte1, byte0};
		if (wb_op inside {OP_SAVE, OP_SAVE0, OP_SAVE1})
			wdata_next = {acc[1], acc[0]}; // Whole accumulator words
		case (wb_op)
			OP_STORE, OP_RELU: wen_next = 8'h03;
			OP_STORE0, OP_RELU0: wen_next = 8'h01;
			OP_STORE1, OP_RELU1: wen_next = 8'h02;
			OP_SAVE: wen_next = 8'hff;
			OP_SAVE0: wen_next = 8'h0f;
			OP_SAVE1: wen_next = 8'hf0;
			default: wen_next = '0;
		endcase
		if (!wb_valid)
			wen_next = '0;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dly_valid <= '0;
			wr_en <= '0;
		end else begin
			dly_valid <= {dly_valid[LANE_LATENCY-2:0], feed.valid};
			wr_en <= wen_next; // Loads at E10
		end
	end

	always_ff @(posedge clock) begin
		dly_op[0] <= feed.op;
		dly_maddr[0] <= feed.maddr;
		for (int i = 1; i < LANE_LATENCY; i++) begin
			dly_op[i] <= dly_op[i-1];
			dly_maddr[i] <= dly_maddr[i-1];
		end
		wr_addr <= dly_maddr[LANE_LATENCY-1] + sbp;
		wr_data <= wdata_next;
		if (wb_valid && wb_op inside {OP_SET_SBP, OP_ADD_SBP})
			sbp <= dly_maddr[LANE_LATENCY-1] + (wb_op == OP_ADD_SBP ? sbp : '0);
	end

	// Odd byte address moves the whole write up one byte lane
	assign mem_wen = wr_addr[0] ? {wr_en[6:0], 1'b0} : wr_en;
	assign mem_wdata = wr_addr[0] ? {wr_data[55:0], 8'h00} : wr_data;
	assign mem_ren = rd_en;
	assign mem_addr = rd_en ? rd_addr : wr_addr[16:1];

	// Issue interlock must keep reads off the bus while a write is out
	assert property (@(posedge clock) disable iff (reset)
		!(rd_en && mem_wen != '0));

endmodule

`default_nettype wire

/* logic/nn_compute.sv */
// Top level of the compute unit; connects issue, operand fetch, the lanes and write-back
`timescale 1ns/1ps
`default_nettype none

module nn_compute #(
	parameter int COEFF_DEPTH = 512
) (
	input  logic                   clock,
	input  logic                   reset,
	output logic                   busy,
	input  logic                   cmd_valid,
	output logic                   cmd_ready,
	input  nn_isa_pkg::insn_t      cmd_insn,
	output logic                   mem_ren,
	output nn_arch_pkg::mem_wen_t  mem_wen,
	output nn_arch_pkg::mem_addr_t mem_addr,
	output nn_arch_pkg::mem_word_t mem_wdata,
	input  nn_arch_pkg::mem_word_t mem_rdata
);
	import nn_isa_pkg::*;
	import nn_arch_pkg::*;

	logic issue_valid;
	insn_t issue_insn;
	logic rd_en;
	mem_addr_t rd_addr;
	acc_t lane_acc [NUM_LANES];
	logic [7:0] lane_sat [NUM_LANES];

	nn_feed_if feed_if ();

	nn_issue issue_i (
		.clock       (clock),
		.reset       (reset),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd_insn    (cmd_insn),
		.busy        (busy),
		.issue_valid (issue_valid),
		.issue_insn  (issue_insn),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr)
	);

	nn_operand_fetch #(
		.COEFF_DEPTH (COEFF_DEPTH)
	) fetch_i (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue_insn  (issue_insn),
		.mem_rdata   (mem_rdata),
		.feed        (feed_if.source)
	);

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		nn_mac_lane #(
			.LANE (g)
		) lane_i (
			.clock (clock),
			.reset (reset),
			.feed  (feed_if.lane),
			.acc   (lane_acc[g]),
			.sat   (lane_sat[g])
		);
	end

	nn_writeback writeback_i (
		.clock     (clock),
		.reset     (reset),
		.feed      (feed_if.sink),
		.acc       (lane_acc),
		.sat       (lane_sat),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.mem_ren   (mem_ren),
		.mem_wen   (mem_wen),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

endmodule

`default_nettype wire

/* verif/nn_compute_tb.sv */
// Directed testbench for the compute unit with a fixed-latency memory model; top of the simulation
`timescale 1ns/1ps
`default_nettype none

module nn_compute_tb;
	import nn_isa_pkg::*;
	import nn_arch_pkg::*;

	localparam int TIMEOUT = 200; // Cycles allowed for any single wait

	logic clock = 1'b0;
	logic reset;
	logic busy;
	logic cmd_valid;
	logic cmd_ready;
	insn_t cmd_insn;
	logic mem_ren;
	mem_wen_t mem_wen;
	mem_addr_t mem_addr;
	mem_word_t mem_wdata;
	mem_word_t mem_rdata;

	mem_word_t mem [65536];
	mem_word_t rd_pipe [MEM_READ_LATENCY] = '{default: '0};
	logic filled = 1'b0;
	integer seed = 32'h9989f343;
	int conflicts = 0;          // Counted by the memory model
	logic poke_en;
	mem_addr_t poke_addr;
	mem_word_t poke_data;
	int errors = 0;

	always #4 clock = ~clock;

	nn_compute #(
		.COEFF_DEPTH (512)
	) nn_compute_i (
		.clock     (clock),
		.reset     (reset),
		.busy      (busy),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_insn  (cmd_insn),
		.mem_ren   (mem_ren),
		.mem_wen   (mem_wen),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	assign mem_rdata = rd_pipe[MEM_READ_LATENCY-1];

	// Memory with a three-edge read pipeline and random contents from the first edge
	always @(posedge clock) begin
		if (!filled) begin
			for (int i = 0; i < 65536; i++)
				mem[i[15:0]] = {$random(seed), $random(seed)};
			filled = 1'b1;
		end
		if (!reset && mem_ren && mem_wen != '0) begin
			conflicts = conflicts + 1;
			$display("Memory read and write were both active at %0t", $time);
		end
		rd_pipe[0] <= mem_ren ? mem[mem_addr] : '0;
		for (int i = 1; i < MEM_READ_LATENCY; i++)
			rd_pipe[i] <= rd_pipe[i-1];
		for (int b = 0; b < 8; b++)
			if (mem_wen[b])
				mem[mem_addr][8*b +: 8] = mem_wdata[8*b +: 8];
		if (poke_en)
			mem[poke_addr] = poke_data; // Test setup while the unit is idle
	end

	task automatic finish_run();
		$display("Errors: %0d, memory conflicts: %0d", errors, conflicts);
		if (errors == 0 && conflicts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
		if (got !== expected) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic send_insn(input opcode_t op, input maddr_t maddr, input caddr_t caddr);
		int n;
		n = 0;
		cmd_insn = '{maddr: maddr, caddr: caddr, op: op};
		cmd_valid = 1'b1;
		while (!cmd_ready && n < TIMEOUT) begin
			@(negedge clock);
			n++;
		end
		if (!cmd_ready) begin
			errors++;
			$display("Command %s was never accepted", op.name());
			finish_run();
		end else begin
			@(negedge clock); // Taken at the rising edge in between
			cmd_valid = 1'b0;
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < TIMEOUT) begin
			@(negedge clock);
			n++;
		end
		if (busy) begin
			errors++;
			$display("Unit still busy after %0d cycles", TIMEOUT);
			finish_run();
		end
	endtask

	task automatic poke(input mem_addr_t addr, input mem_word_t data);
		poke_en = 1'b1;
		poke_addr = addr;
		poke_data = data;
		@(negedge clock);
		poke_en = 1'b0;
	endtask

	// Sum of eight signed byte products
	function automatic int dot(input mem_word_t d, input mem_word_t c);
		int s;
		s = 0;
		for (int b = 0; b < 8; b++)
			s += $signed(d[8*b +: 8]) * $signed(c[8*b +: 8]);
		return s;
	endfunction

	function automatic logic [7:0] sat_ref(input int acc, input int shift);
		int v;
		v = (shift > 31) ? ((acc < 0) ? -1 : 0) : (acc >>> shift);
		if (v > 127)
			return 8'h7f;
		if (v < -128)
			return 8'h80;
		return v[7:0];
	endfunction

	function automatic logic [7:0] relu_ref(input logic [7:0] b);
		return b[7] ? 8'h00 : b;
	endfunction

	function automatic mem_word_t put_byte(input mem_word_t w, input int pos, input logic [7:0] b);
		mem_word_t r;
		r = w;
		r[8*pos +: 8] = b;
		return r;
	endfunction

	task automatic reset_values();
		check("cmd_ready", cmd_ready, 1);
		check("busy", busy, 0);
		check("mem_ren", mem_ren, 0);
		check("mem_wen", mem_wen, 0);
	endtask

	task automatic coeff_dot_product();
		mem_word_t c0;
		mem_word_t c1;
		mem_word_t d;
		c0 = mem[16'h0080];
		c1 = mem[16'h0081];
		d = mem[16'h0100];
		send_insn(OP_SET_VBP, 17'h0, 9'd0);
		send_insn(OP_SET_SBP, 17'h0, 9'd0);
		send_insn(OP_LOAD_COEFF0, 17'h0100, 9'd3);
		send_insn(OP_LOAD_COEFF1, 17'h0102, 9'd3);
		send_insn(OP_MACCZ, 17'h0200, 9'd3); // Held until row 3 is written
		send_insn(OP_SAVE, 17'h0400, 9'd0);
		wait_idle();
		check("mem word 0x200", mem[16'h0200], {dot(d, c1), dot(d, c0)});
	endtask

	task automatic accumulate_with_pointers();
		mem_addr_t words [4] = '{16'h0180, 16'h0181, 16'h0182, 16'h0184};
		mem_word_t c0;
		mem_word_t c1;
		mem_word_t old0;
		mem_word_t old1;
		int acc0;
		int acc1;
		c0 = mem[16'h0090];
		c1 = mem[16'h0091];
		old0 = mem[16'h0308];
		old1 = mem[16'h030a];
		acc0 = 0;
		acc1 = 0;
		foreach (words[k]) begin
			acc0 += dot(mem[words[k]], c0);
			acc1 += dot(mem[words[k]], c1);
		end
		send_insn(OP_LOAD_COEFF0, 17'h0120, 9'd5);
		send_insn(OP_LOAD_COEFF1, 17'h0122, 9'd5);
		send_insn(OP_SET_VBP, 17'h0300, 9'd0);
		send_insn(OP_MACCZ, 17'h0, 9'd5);
		send_insn(OP_ADD_VBP, 17'h2, 9'd0);
		send_insn(OP_MACC, 17'h0, 9'd5);
		send_insn(OP_ADD_VBP, 17'h2, 9'd0);
		send_insn(OP_MACC, 17'h0, 9'd5);
		send_insn(OP_ADD_VBP, 17'h2, 9'd0);
		send_insn(OP_MACC, 17'h2, 9'd5);    // Offset on top of VBP
		send_insn(OP_SET_SBP, 17'h0600, 9'd0);
		send_insn(OP_SAVE0, 17'h0010, 9'd0);
		send_insn(OP_SAVE1, 17'h0014, 9'd0);
		wait_idle();
		check("mem word 0x308", mem[16'h0308], {old0[63:32], acc0});
		check("mem word 0x30a", mem[16'h030a], {acc1, old1[31:0]});
	endtask

	task automatic saturate_stores();
		mem_addr_t at [6] = '{16'h0400, 16'h0408, 16'h0410, 16'h0418, 16'h0420, 16'h0428};
		mem_word_t old [6];
		int pos;
		int neg;
		poke(16'h00a0, {8{8'h7f}});
		poke(16'h00a1, {8{8'h81}});
		poke(16'h01a0, {8{8'd100}});
		pos = dot(mem[16'h01a0], mem[16'h00a0]);
		neg = dot(mem[16'h01a0], mem[16'h00a1]);
		foreach (at[k])
			old[k] = mem[at[k]];
		send_insn(OP_SET_VBP, 17'h0, 9'd0);
		send_insn(OP_SET_SBP, 17'h0, 9'd0);
		send_insn(OP_LOAD_COEFF0, 17'h0140, 9'd7);
		send_insn(OP_LOAD_COEFF1, 17'h0142, 9'd7);
		send_insn(OP_MACCZ, 17'h0340, 9'd7);
		send_insn(OP_STORE, 17'h0800, 9'd0);
		send_insn(OP_STORE, 17'h0810, 9'd10);
		send_insn(OP_STORE, 17'h0820, 9'd20);
		send_insn(OP_STORE0, 17'h0831, 9'd10); // Odd address lands in byte 1
		send_insn(OP_STORE1, 17'h0840, 9'd10);
		send_insn(OP_STORE1, 17'h0851, 9'd0);
		wait_idle();
		check("mem word 0x400", mem[at[0]],
			put_byte(put_byte(old[0], 0, sat_ref(pos, 0)), 1, sat_ref(neg, 0)));
		check("mem word 0x408", mem[at[1]],
			put_byte(put_byte(old[1], 0, sat_ref(pos, 10)), 1, sat_ref(neg, 10)));
		check("mem word 0x410", mem[at[2]],
			put_byte(put_byte(old[2], 0, sat_ref(pos, 20)), 1, sat_ref(neg, 20)));
		check("mem word 0x418", mem[at[3]], put_byte(old[3], 1, sat_ref(pos, 10)));
		check("mem word 0x420", mem[at[4]], put_byte(old[4], 1, sat_ref(neg, 10)));
		check("mem word 0x428", mem[at[5]], put_byte(old[5], 2, sat_ref(neg, 0)));
	endtask

	task automatic relu_stores();
		mem_word_t old0;
		mem_word_t old1;
		mem_word_t old2;
		int pos;
		int neg;
		poke(16'h01b0, {8{8'd5}});
		pos = dot(mem[16'h01b0], mem[16'h00a0]);
		neg = dot(mem[16'h01b0], mem[16'h00a1]);
		old0 = mem[16'h0500];
		old1 = mem[16'h0510];
		old2 = mem[16'h0520];
		send_insn(OP_MACCZ, 17'h0360, 9'd7); // Row 7 still holds +127 and -127
		send_insn(OP_RELU, 17'h0a00, 9'd6);
		send_insn(OP_RELU0, 17'h0a21, 9'd6);
		send_insn(OP_RELU1, 17'h0a40, 9'd0);
		wait_idle();
		check("mem word 0x500", mem[16'h0500], put_byte(put_byte(old0, 0,
			relu_ref(sat_ref(pos, 6))), 1, relu_ref(sat_ref(neg, 6))));
		check("mem word 0x510", mem[16'h0510], put_byte(old1, 1, relu_ref(sat_ref(pos, 6))));
		check("mem word 0x520", mem[16'h0520], put_byte(old2, 1, relu_ref(sat_ref(neg, 0))));
	endtask

	task automatic save_then_read();
		mem_word_t c0;
		mem_word_t c1;
		mem_word_t d;
		mem_word_t saved;
		c0 = mem[16'h0080];
		c1 = mem[16'h0081];
		d = mem[16'h0100];
		saved = {dot(d, c1), dot(d, c0)};
		send_insn(OP_SET_VBP, 17'h0, 9'd0);
		send_insn(OP_SET_SBP, 17'h0, 9'd0);
		send_insn(OP_MACCZ, 17'h0200, 9'd3);
		send_insn(OP_SAVE, 17'h0c00, 9'd0);
		send_insn(OP_MACC, 17'h0c00, 9'd3); // Must read what the Save wrote
		send_insn(OP_SAVE, 17'h0c10, 9'd0);
		wait_idle();
		check("mem word 0x600", mem[16'h0600], saved);
		check("mem word 0x608", mem[16'h0608],
			{saved[63:32] + dot(saved, c1), saved[31:0] + dot(saved, c0)});
	endtask

	initial begin
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_insn = '0;
		poke_en = 1'b0;
		poke_addr = '0;
		poke_data = '0;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		reset_values();
		coeff_dot_product();
		accumulate_with_pointers();
		saturate_stores();
		relu_stores();
		save_then_read();
		finish_run();
	end

endmodule

`default_nettype wire

/* flist.f */
logic/nn_isa_pkg.sv
logic/nn_arch_pkg.sv
logic/nn_feed_if.sv
logic/nn_issue.sv
logic/nn_operand_fetch.sv
logic/nn_mac_lane.sv
logic/nn_writeback.sv
logic/nn_compute.sv
verif/nn_compute_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the compute unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module nn_compute_tb -o nn_compute_sim \
	|| { echo "Build failed"; exit 1; }

./obj_dir/nn_compute_sim | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
